// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0 --timescale 1ns/100ps
TOP       := branch_predictor_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
RUN_FLAGS := +verilator+error+limit+100
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== source/bht.sv ====
`timescale 1ns/100ps
`default_nettype none

// Tagged 2-bit branch history table.
module bht (
  input  wire logic                   clk,      // System clock.
  input  wire logic                   rst,      // Sync reset.
  input  wire bp_geometry_pkg::pc_t   fetch_pc, // Address being fetched.
  bp_update_if.sink                   upd,      // Resolved branch from decode.
  output logic                        taken,    // Predict taken on tag hit.
  output bp_types_pkg::counter_t      state     // Raw counter at the fetch index.
);

  import bp_geometry_pkg::*;
  import bp_types_pkg::*;

  idx_t       fetch_idx;        // Fetch row.
  tag_t       fetch_tag;        // Fetch tag.
  idx_t       upd_idx;          // Update row.
  tag_t       upd_tag;          // Update tag.
  bht_entry_t entry_curr;       // Row seen by the lookup.
  bht_entry_t entry_prev;       // Row about to be updated.
  bht_entry_t entry_new;        // Row written on update.
  counter_t   next_state;       // Counter after the update.
  logic       read_tag_match;   // Lookup hit.
  logic       write_tag_match;  // Stored row belongs to the updating branch.
  logic       wr_en;            // Gated write strobe.

  assign fetch_idx = fetch_pc[idx_lsb +: idx_w];
  assign fetch_tag = fetch_pc[tag_lsb +: tag_w];
  assign upd_idx   = upd.pc[idx_lsb +: idx_w];
  assign upd_tag   = upd.pc[tag_lsb +: tag_w];

  branch_cache #(
    .data_w (bht_entry_w)
  ) u_cache (
    .clk          (clk),
    .rst          (rst),
    .rd_idx_curr  (fetch_idx),
    .rd_idx_prev  (upd_idx),
    .wr_en        (wr_en),
    .wr_idx       (upd_idx),
    .wr_data      (entry_new),
    .rd_data_curr (entry_curr),
    .rd_data_prev (entry_prev)
  );

  //////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////
  assign state          = counter_t'(entry_curr[cnt_w-1:0]);       // Counter field.
  assign read_tag_match = (entry_curr[bht_entry_w-1 -: tag_w] == fetch_tag);
  assign taken          = read_tag_match & state[cnt_w-1];         // MSB means taken.

  //////////////////////////////////////////////////
  // Update
  //////////////////////////////////////////////////
  assign write_tag_match = (entry_prev[bht_entry_w-1 -: tag_w] == upd_tag);

  // Counter steps from the state that was predicted, not the stored one.
  always_comb begin
    case (upd.state)
      strong_not_taken: begin
        next_state = upd.taken ? weak_not_taken : strong_not_taken;
      end
      weak_not_taken: begin
        if (!write_tag_match) next_state = strong_not_taken; // Row was replaced.
        else next_state = upd.taken ? weak_taken : strong_not_taken;
      end
      weak_taken: begin
        if (!write_tag_match) next_state = strong_not_taken;
        else next_state = upd.taken ? strong_taken : weak_not_taken;
      end
      strong_taken: begin
        if (!write_tag_match) next_state = strong_not_taken;
        else next_state = upd.taken ? strong_taken : weak_taken; // Saturate.
      end
      default: begin
        next_state = strong_not_taken;
      end
    endcase
  end

  assign entry_new = {upd_tag, next_state};                 // Tag always refreshed.
  assign wr_en     = upd.valid & upd.enable;                // Dropped while stalled.

endmodule

`default_nettype wire

// ==== source/bp_geometry_pkg.sv ====
package bp_geometry_pkg;

  //////////////////////////////////////////////////
  // Fetch address layout
  //////////////////////////////////////////////////
  localparam int pc_w    = 16;              // Instruction address width.
  localparam int idx_w   = 3;               // Table index width.
  localparam int tag_w   = 12;              // Tag width.
  localparam int depth   = 1 << idx_w;      // Entries per table.

  // Bit 0 is always zero for halfword aligned instructions.
  localparam int idx_lsb = 1;               // Index is PC[3:1].
  localparam int tag_lsb = idx_lsb + idx_w; // Tag is PC[15:4].

  //////////////////////////////////////////////////
  // Address field types
  //////////////////////////////////////////////////
  typedef logic [pc_w-1:0]  pc_t;           // Instruction address.
  typedef logic [idx_w-1:0] idx_t;          // Table index.
  typedef logic [tag_w-1:0] tag_t;          // Upper PC bits kept for the hit check.

endpackage

// ==== source/bp_types_pkg.sv ====
package bp_types_pkg;

  import bp_geometry_pkg::*;

  //////////////////////////////////////////////////
  // Prediction counter
  //////////////////////////////////////////////////
  localparam int cnt_w = 2;                    // Saturating counter width.

  typedef enum logic [cnt_w-1:0] {
    strong_not_taken = 2'd0,                   // Reset value.
    weak_not_taken   = 2'd1,
    weak_taken       = 2'd2,                   // MSB set means predict taken.
    strong_taken     = 2'd3
  } counter_t;

  //////////////////////////////////////////////////
  // Table entry layouts
  //////////////////////////////////////////////////
  // History entry is {tag, counter}.
  localparam int bht_entry_w = tag_w + cnt_w;  // 14 bits.

  // Target entry is {valid, tag, target}.
  localparam int btb_entry_w = 1 + tag_w + pc_w;  // 29 bits.
  localparam int btb_valid_bit = btb_entry_w - 1; // Valid flag position.

  typedef logic [bht_entry_w-1:0] bht_entry_t; // One history table row.
  typedef logic [btb_entry_w-1:0] btb_entry_t; // One target buffer row.

endpackage

// ==== source/bp_update_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Resolved branch from decode, sent to both prediction tables.
interface bp_update_if;

  import bp_geometry_pkg::*;
  import bp_types_pkg::*;

  pc_t      pc;     // Branch address from the IF/ID register.
  counter_t state;  // Counter value predicted at fetch.
  logic     taken;  // Actual outcome.
  pc_t      target; // Actual target.
  logic     valid;  // Write request.
  logic     enable; // Low while the pipeline stalls.

  // Driven by the predictor top.
  modport source (
    output pc, state, taken, target, valid, enable
  );

  // Seen by the tables.
  modport sink (
    input pc, state, taken, target, valid, enable
  );

endinterface

`default_nettype wire

// ==== source/branch_cache.sv ====
`timescale 1ns/100ps
`default_nettype none

// Small register file shared by the history table and the target buffer.
module branch_cache #(
  parameter int data_w = 14                    // Entry width.
) (
  input  wire logic                  clk,          // System clock.
  input  wire logic                  rst,          // Sync reset, clears all entries.
  input  wire bp_geometry_pkg::idx_t rd_idx_curr,  // Fetch side index.
  input  wire bp_geometry_pkg::idx_t rd_idx_prev,  // Decode side index.
  input  wire logic                  wr_en,        // Write strobe.
  input  wire bp_geometry_pkg::idx_t wr_idx,       // Write index.
  input  wire logic [data_w-1:0]     wr_data,      // Entry to store.
  output logic [data_w-1:0]          rd_data_curr, // Entry at rd_idx_curr.
  output logic [data_w-1:0]          rd_data_prev  // Entry at rd_idx_prev.
);

  import bp_geometry_pkg::*;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////
  logic [data_w-1:0] mem [depth];              // One row per index.

  // Zeroed rows read as not-taken and invalid.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= '0;                          // Clear every row.
      end
    end else if (wr_en) begin
      mem[wr_idx] <= wr_data;                  // Visible to reads next cycle.
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////
  // Both are asynchronous, so same cycle reads return old contents.
  assign rd_data_curr = mem[rd_idx_curr];      // Lookup port.
  assign rd_data_prev = mem[rd_idx_prev];      // Read-before-update port.

endmodule

`default_nettype wire

// ==== source/branch_predictor.sv ====
`timescale 1ns/100ps
`default_nettype none

// Fetch stage branch predictor, history table plus target buffer.
module branch_predictor (
  input  wire logic                   clk,            // System clock.
  input  wire logic                   rst,            // Sync reset.
  input  wire logic                   enable,         // Pipeline not stalled.
  input  wire bp_geometry_pkg::pc_t   fetch_pc,       // Current fetch address.
  output logic                        predict_taken,  // Redirect fetch.
  output bp_geometry_pkg::pc_t        predict_target, // Redirect address.
  output bp_types_pkg::counter_t      predict_state,  // Carried down the pipe.
  input  wire logic                   update_valid,   // Branch resolved in decode.
  input  wire bp_geometry_pkg::pc_t   update_pc,      // Its address.
  input  wire bp_types_pkg::counter_t update_state,   // Its predicted counter.
  input  wire logic                   update_taken,   // Its outcome.
  input  wire bp_geometry_pkg::pc_t   update_target   // Its real target.
);

  import bp_geometry_pkg::*;
  import bp_types_pkg::*;

  logic     bht_taken;   // History says taken.
  counter_t bht_state;   // Counter at fetch index.
  logic     btb_hit;     // Target known.
  pc_t      btb_target;  // Stored target.

  //////////////////////////////////////////////////
  // Update bundle
  //////////////////////////////////////////////////
  bp_update_if u_upd ();

  assign u_upd.pc     = update_pc;
  assign u_upd.state  = update_state;
  assign u_upd.taken  = update_taken;
  assign u_upd.target = update_target;
  assign u_upd.valid  = update_valid;
  assign u_upd.enable = enable;          // Stall drops the update.

  //////////////////////////////////////////////////
  // Tables
  //////////////////////////////////////////////////
  bht u_bht (
    .clk      (clk),
    .rst      (rst),
    .fetch_pc (fetch_pc),
    .upd      (u_upd.sink),
    .taken    (bht_taken),
    .state    (bht_state)
  );

  btb u_btb (
    .clk      (clk),
    .rst      (rst),
    .fetch_pc (fetch_pc),
    .upd      (u_upd.sink),
    .hit      (btb_hit),
    .target   (btb_target)
  );

  // A taken guess is useless without somewhere to go.
  assign predict_taken  = bht_taken & btb_hit;
  assign predict_target = btb_hit ? btb_target : '0;  // Zero on a miss.
  assign predict_state  = bht_state;                  // Untouched by the hit check.

endmodule

`default_nettype wire

// ==== source/btb.sv ====
`timescale 1ns/100ps
`default_nettype none

// Tagged branch target buffer.
module btb (
  input  wire logic                 clk,      // System clock.
  input  wire logic                 rst,      // Sync reset, all rows invalid.
  input  wire bp_geometry_pkg::pc_t fetch_pc, // Address being fetched.
  bp_update_if.sink                 upd,      // Resolved branch from decode.
  output logic                      hit,      // Valid row with matching tag.
  output bp_geometry_pkg::pc_t      target    // Stored target.
);

  import bp_geometry_pkg::*;
  import bp_types_pkg::*;

  idx_t       fetch_idx;   // Fetch row.
  tag_t       fetch_tag;   // Fetch tag.
  idx_t       upd_idx;     // Update row.
  btb_entry_t entry_curr;  // Row seen by the lookup.
  btb_entry_t entry_new;   // Row written on a taken update.
  logic       entry_valid; // Valid flag of the lookup row.
  tag_t       entry_tag;   // Tag of the lookup row.
  logic       wr_en;       // Gated write strobe.

  assign fetch_idx = fetch_pc[idx_lsb +: idx_w];
  assign fetch_tag = fetch_pc[tag_lsb +: tag_w];
  assign upd_idx   = upd.pc[idx_lsb +: idx_w];

  // Second read port is not needed here.
  branch_cache #(
    .data_w (btb_entry_w)
  ) u_cache (
    .clk          (clk),
    .rst          (rst),
    .rd_idx_curr  (fetch_idx),
    .rd_idx_prev  (upd_idx),
    .wr_en        (wr_en),
    .wr_idx       (upd_idx),
    .wr_data      (entry_new),
    .rd_data_curr (entry_curr),
    .rd_data_prev ()
  );

  //////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////
  assign entry_valid = entry_curr[btb_valid_bit];                 // Top bit.
  assign entry_tag   = entry_curr[btb_valid_bit-1 -: tag_w];      // Middle field.
  assign target      = entry_curr[pc_w-1:0];                      // Low field.
  assign hit         = entry_valid & (entry_tag == fetch_tag);

  //////////////////////////////////////////////////
  // Update
  //////////////////////////////////////////////////
  assign entry_new = {1'b1, upd.pc[tag_lsb +: tag_w], upd.target}; // Mark valid.

  // Only taken branches install a target. Not-taken ones keep the old row.
  assign wr_en = upd.valid & upd.enable & upd.taken;

endmodule

`default_nettype wire

// ==== sources.f ====
source/bp_geometry_pkg.sv
source/bp_types_pkg.sv
source/bp_update_if.sv
source/branch_cache.sv
source/bht.sv
source/btb.sv
source/branch_predictor.sv
verif/branch_predictor_assertions.sv
verif/branch_predictor_tb.sv

// ==== verif/branch_predictor_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

// Output checks bound into the predictor top.
module branch_predictor_assertions (
  input wire logic                   clk,
  input wire logic                   rst,
  input wire logic                   enable,         // Pipeline not stalled.
  input wire logic                   update_valid,
  input wire logic                   update_taken,
  input wire logic                   predict_taken,
  input wire bp_geometry_pkg::pc_t   predict_target,
  input wire bp_types_pkg::counter_t predict_state
);

  int   fail_count = 0; // Read back by the testbench at the end.
  logic any_write;      // Some taken update has reached the target buffer.

  always_ff @(posedge clk) begin
    if (rst) begin
      any_write <= 1'b0;
    end else if (update_valid && enable && update_taken) begin
      any_write <= 1'b1;                               // Target row installed.
    end
  end

  //////////////////////////////////////////////////
  // Prediction outputs
  //////////////////////////////////////////////////
  taken_needs_msb: assert property (@(posedge clk) disable iff (rst)
    predict_taken |-> predict_state[1])
    else begin
      fail_count++;
      $error("predict_taken is high with a not-taken counter state");
    end

  no_taken_after_reset: assert property (@(posedge clk)
    rst |=> !predict_taken)
    else begin
      fail_count++;
      $error("predict_taken is high right after reset");
    end

  // Empty target buffer can never produce an address.
  target_zero_before_write: assert property (@(posedge clk) disable iff (rst)
    !any_write |-> (predict_target == '0))
    else begin
      fail_count++;
      $error("predict_target is not zero before any target was written");
    end

endmodule

`default_nettype wire

// ==== verif/branch_predictor_cases.txt ====
# op pc state taken target exp_taken exp_target exp_state, all fields in hex
# L lookup, U update, S update while stalled, W update and lookup in one cycle
# Reset state
L 1234 0 0 0000 0 0000 0
L 5674 0 0 0000 0 0000 0
L 0abc 0 0 0000 0 0000 0
# Counter training on 1234, index 2, tag 123
U 1234 0 1 2000 0 0000 0
L 1234 0 0 0000 0 2000 1
U 1234 1 1 2000 0 0000 0
L 1234 0 0 0000 1 2000 2
U 1234 2 1 2000 0 0000 0
L 1234 0 0 0000 1 2000 3
U 1234 3 1 2000 0 0000 0
L 1234 0 0 0000 1 2000 3
# Decrement, target kept
U 1234 3 0 0000 0 0000 0
L 1234 0 0 0000 1 2000 2
U 1234 2 0 0000 0 0000 0
L 1234 0 0 0000 0 2000 1
U 1234 1 0 0000 0 0000 0
L 1234 0 0 0000 0 2000 0
# Retrain to weak taken
U 1234 0 1 2000 0 0000 0
U 1234 1 1 2000 0 0000 0
L 1234 0 0 0000 1 2000 2
# Tag conflict, 5674 shares index 2 with tag 567
L 5674 0 0 0000 0 0000 2
U 5674 2 1 3000 0 0000 0
L 5674 0 0 0000 0 3000 0
L 1234 0 0 0000 0 0000 0
# Stalled update is dropped
S 5674 0 1 4444 0 0000 0
L 5674 0 0 0000 0 3000 0
# Same cycle lookup sees old contents
W 5674 0 1 3000 0 3000 0
L 5674 0 0 0000 0 3000 1
W 5674 1 1 3000 0 3000 1
L 5674 0 0 0000 1 3000 2
L 0abc 0 0 0000 0 0000 0

// ==== verif/branch_predictor_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_predictor_tb;

  import bp_geometry_pkg::*;
  import bp_types_pkg::*;

  //////////////////////////////////////////////////
  // Run constants
  //////////////////////////////////////////////////
  localparam string cases_path   = "verif/branch_predictor_cases.txt";
  localparam real   drive_skew   = 0.5;  // Input delay after the rising edge, ns.
  localparam int    reset_cycles = 2;

  // One line of the cases file.
  typedef struct packed {
    logic [15:0] line_no;                // Source line, for error messages.
    logic [7:0]  op;                     // L, U, S or W.
    pc_t         pc;
    logic [1:0]  state;
    logic        taken;
    pc_t         target;
    logic        exp_taken;
    pc_t         exp_target;
    logic [1:0]  exp_state;
  } case_t;

  logic     clk;
  logic     rst;
  logic     enable;
  pc_t      fetch_pc;
  logic     predict_taken;
  pc_t      predict_target;
  counter_t predict_state;
  logic     update_valid;
  pc_t      update_pc;
  counter_t update_state;
  logic     update_taken;
  pc_t      update_target;

  case_t cases [$];                      // Whole file, loaded at time zero.
  int    errors       = 0;
  int    checks       = 0;
  int    cycle_count  = 0;
  int    cycle_limit  = 20;              // Raised once the case count is known.
  int    assert_fails = 0;

  //////////////////////////////////////////////////
  // DUT
  //////////////////////////////////////////////////
  branch_predictor u_dut (
    .clk            (clk),
    .rst            (rst),
    .enable         (enable),
    .fetch_pc       (fetch_pc),
    .predict_taken  (predict_taken),
    .predict_target (predict_target),
    .predict_state  (predict_state),
    .update_valid   (update_valid),
    .update_pc      (update_pc),
    .update_state   (update_state),
    .update_taken   (update_taken),
    .update_target  (update_target)
  );

  bind branch_predictor branch_predictor_assertions u_assertions (
    .clk            (clk),
    .rst            (rst),
    .enable         (enable),
    .update_valid   (update_valid),
    .update_taken   (update_taken),
    .predict_taken  (predict_taken),
    .predict_target (predict_target),
    .predict_state  (predict_state)
  );

  always #2 clk = ~clk;                  // 4 ns period.

  //////////////////////////////////////////////////
  // Cases file
  //////////////////////////////////////////////////
  task automatic load_cases(output bit ok);
    int    fd;
    int    line_no;
    int    fields;
    string line;
    string op_s;
    int    f_pc;
    int    f_state;
    int    f_taken;
    int    f_target;
    int    f_exp_taken;
    int    f_exp_target;
    int    f_exp_state;
    case_t c;
    ok      = 1'b0;
    line_no = 0;
    fd      = $fopen(cases_path, "r");
    if (fd == 0) begin
      $display("Cannot open the cases file %s.", cases_path);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      line_no++;
      if (line.len() < 2 || line.getc(0) == "#") continue;  // Blank or comment.
      fields = $sscanf(line, "%s %h %h %h %h %h %h %h", op_s, f_pc, f_state, f_taken,
                       f_target, f_exp_taken, f_exp_target, f_exp_state);
      if (fields != 8) begin
        $display("Line %0d of the cases file could not be read.", line_no);
        errors++;
        continue;
      end
      c.line_no    = line_no[15:0];
      c.op         = op_s.getc(0);
      c.pc         = f_pc[15:0];
      c.state      = f_state[1:0];
      c.taken      = f_taken[0];
      c.target     = f_target[15:0];
      c.exp_taken  = f_exp_taken[0];
      c.exp_target = f_exp_target[15:0];
      c.exp_state  = f_exp_state[1:0];
      cases.push_back(c);
    end
    $fclose(fd);
    ok = (cases.size() > 0);
    if (!ok) $display("The cases file holds no cases.");
  endtask

  //////////////////////////////////////////////////
  // Drive and check
  //////////////////////////////////////////////////
  task automatic apply_case(input case_t c);
    fetch_pc      = c.pc;                // Lookup runs every cycle.
    update_pc     = c.pc;
    update_state  = counter_t'(c.state);
    update_taken  = c.taken;
    update_target = c.target;
    update_valid  = (c.op != "L");       // Plain lookups send no update.
    enable        = (c.op != "S");       // Stalled update.
    if (c.op != "L" && c.op != "U" && c.op != "S" && c.op != "W") begin
      $display("Unknown operation code on line %0d of the cases file.", c.line_no);
      errors++;
    end
  endtask

  task automatic check_lookup(input case_t c);
    checks++;
    assert (predict_taken === c.exp_taken) else begin
      errors++;
      $display("CHECK FAILED predict_taken: got 0x%h, expected 0x%h (cases line %0d)",
               predict_taken, c.exp_taken, c.line_no);
    end
    assert (predict_target === c.exp_target) else begin
      errors++;
      $display("CHECK FAILED predict_target: got 0x%h, expected 0x%h (cases line %0d)",
               predict_target, c.exp_target, c.line_no);
    end
    assert (predict_state === c.exp_state) else begin
      errors++;
      $display("CHECK FAILED predict_state: got 0x%h, expected 0x%h (cases line %0d)",
               predict_state, c.exp_state, c.line_no);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin : main
    bit loaded;
    clk           = 1'b0;
    rst           = 1'b1;
    enable        = 1'b1;
    fetch_pc      = '0;
    update_valid  = 1'b0;
    update_pc     = '0;
    update_state  = strong_not_taken;
    update_taken  = 1'b0;
    update_target = '0;
    load_cases(loaded);
    if (loaded) begin
      cycle_limit = 4 * cases.size() + 20;
      repeat (reset_cycles) @(posedge clk);
      #(drive_skew);
      rst = 1'b0;
      foreach (cases[i]) begin
        @(posedge clk);
        #(drive_skew);
        apply_case(cases[i]);
        if (cases[i].op == "L" || cases[i].op == "W") begin
          @(negedge clk);                // Outputs settled, mid cycle.
          check_lookup(cases[i]);
        end
      end
      @(posedge clk);
      #(drive_skew);
      update_valid = 1'b0;               // Idle bus at the end.
    end else begin
      errors++;
    end
    assert_fails = u_dut.u_assertions.fail_count;
    $display("Summary: %0d checks, %0d check errors, %0d assertion failures",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Cycle limit guard.
  initial begin : watchdog
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire
